// ==== hdl/issue_pkg.sv ====
`include "issue_consts.svh"

package issue_pkg;

    // execution unit targeted by a slot
    typedef enum logic [2:0] {
        eu_alu   = 3'd0,
        eu_lsu   = 3'd1,
        eu_mext  = 3'd2,
        eu_float = 3'd3,
        eu_csr   = 3'd4
    } eu_e;

    // physical register id
    typedef logic [`PHY_REG_ID_WIDTH-1:0] preg_id_t;

    // register data word
    typedef logic [`REG_WIDTH-1:0] word_t;

endpackage

// ==== hdl/issue_select.sv ====
`include "issue_consts.svh"

module issue_select
    import issue_pkg::*;
(
    // renamed window
    input  logic [`ISSUE_WIDTH-1:0] inst_vld,
    input  preg_id_t                inst_rs1      [`ISSUE_WIDTH-1:0],
    input  logic [`ISSUE_WIDTH-1:0] inst_rs1_en,
    input  preg_id_t                inst_rs2      [`ISSUE_WIDTH-1:0],
    input  logic [`ISSUE_WIDTH-1:0] inst_rs2_en,
    input  preg_id_t                inst_rd       [`ISSUE_WIDTH-1:0],
    input  logic [`ISSUE_WIDTH-1:0] inst_rd_en,
    input  eu_e                     inst_unit     [`ISSUE_WIDTH-1:0],

    // unit hazards already resolved
    input  logic [`ISSUE_WIDTH-1:0] unit_ok,

    // operand lookup and busy marking
    operand_if.sel_side             ops,

    // issue side
    output logic [`ISSUE_WIDTH-1:0] inst_rdy,
    output logic [`ISSUE_WIDTH-1:0] issue_en,
    output word_t                   issue_rs1_val [`ISSUE_WIDTH-1:0],
    output word_t                   issue_rs2_val [`ISSUE_WIDTH-1:0],
    output preg_id_t                issue_rd      [`ISSUE_WIDTH-1:0],
    output eu_e                     issue_unit    [`ISSUE_WIDTH-1:0]
);

    logic [`ISSUE_WIDTH-1:0] src_ok;
    logic [`ISSUE_WIDTH-1:0] raw_hit;
    logic [`ISSUE_WIDTH-1:0] is_mext;

    // ####################
    // operand readiness
    // ####################

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_src
        assign ops.rs1_id[i] = inst_rs1[i];
        assign ops.rs2_id[i] = inst_rs2[i];
        // unused sources never block
        assign src_ok[i] = (!inst_rs1_en[i] || ops.rs1_rdy[i]) &&
                           (!inst_rs2_en[i] || ops.rs2_rdy[i]);
    end

    // ####################
    // intra-window raw
    // ####################

    // earlier producer in the same window, valid or not
    always_comb begin
        raw_hit = '0;
        for (int i = 1; i < `ISSUE_WIDTH; i++) begin
            for (int j = 0; j < i; j++) begin
                if (inst_rd_en[j]) begin
                    if (inst_rs1_en[i] && inst_rs1[i] == inst_rd[j]) begin
                        raw_hit[i] = 1'b1;
                    end
                    if (inst_rs2_en[i] && inst_rs2[i] == inst_rd[j]) begin
                        raw_hit[i] = 1'b1;
                    end
                end
            end
        end
    end

    // ####################
    // issue
    // ####################

    assign issue_en     = inst_vld & unit_ok & src_ok & ~raw_hit;
    // ready mirrors issue, no skid state
    assign inst_rdy     = issue_en;
    assign ops.issue_en = issue_en;
    assign ops.rd_en    = inst_rd_en;

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_out
        assign ops.rd_id[i]      = inst_rd[i];
        assign issue_rs1_val[i]  = ops.rs1_val[i];
        assign issue_rs2_val[i]  = ops.rs2_val[i];
        assign issue_rd[i]       = inst_rd[i];
        assign issue_unit[i]     = inst_unit[i];
        assign is_mext[i]        = inst_unit[i] == eu_mext;

        a_issue_vld : assert final (!issue_en[i] || inst_vld[i])
            else $error("slot %0d issued without valid", i);
    end

    // the hazard checker alone keeps mext single per window
    a_one_mext : assert final ($countones(issue_en & is_mext) <= 1)
        else $error("more than one mext slot issued");

endmodule

// ==== hdl/issue_top.sv ====
`include "issue_consts.svh"

module issue_top
    import issue_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,

    // renamed window
    input  logic [`ISSUE_WIDTH-1:0]   inst_vld,
    input  preg_id_t                  inst_rs1      [`ISSUE_WIDTH-1:0],
    input  logic [`ISSUE_WIDTH-1:0]   inst_rs1_en,
    input  preg_id_t                  inst_rs2      [`ISSUE_WIDTH-1:0],
    input  logic [`ISSUE_WIDTH-1:0]   inst_rs2_en,
    input  preg_id_t                  inst_rd       [`ISSUE_WIDTH-1:0],
    input  logic [`ISSUE_WIDTH-1:0]   inst_rd_en,
    input  eu_e                       inst_unit     [`ISSUE_WIDTH-1:0],
    input  logic [`LSU_DEPTH_WIDTH:0] inst_lsu_id   [`ISSUE_WIDTH-1:0],

    // unit readiness and lsu order
    input  logic                      mext_rdy,
    input  logic                      float_rdy,
    input  logic [`LSU_DEPTH_WIDTH:0] lsu_rd_ptr,

    // writeback
    input  logic [`WB_PORTS-1:0]      wb_en,
    input  preg_id_t                  wb_id         [`WB_PORTS-1:0],
    input  word_t                     wb_data       [`WB_PORTS-1:0],

    // issue
    output logic [`ISSUE_WIDTH-1:0]   inst_rdy,
    output logic [`ISSUE_WIDTH-1:0]   issue_en,
    output word_t                     issue_rs1_val [`ISSUE_WIDTH-1:0],
    output word_t                     issue_rs2_val [`ISSUE_WIDTH-1:0],
    output preg_id_t                  issue_rd      [`ISSUE_WIDTH-1:0],
    output eu_e                       issue_unit    [`ISSUE_WIDTH-1:0]
);

    logic [`ISSUE_WIDTH-1:0] unit_ok;

    // file to selector operand path
    operand_if u_ops ();

    phy_reg_file u_prf (
        .clk     (clk),
        .rst_n   (rst_n),
        .wb_en   (wb_en),
        .wb_id   (wb_id),
        .wb_data (wb_data),
        .ops     (u_ops.reg_side)
    );

    unit_hazard_check u_hazard (
        .inst_unit   (inst_unit),
        .inst_lsu_id (inst_lsu_id),
        .mext_rdy    (mext_rdy),
        .float_rdy   (float_rdy),
        .lsu_rd_ptr  (lsu_rd_ptr),
        .unit_ok     (unit_ok)
    );

    issue_select u_sel (
        .inst_vld      (inst_vld),
        .inst_rs1      (inst_rs1),
        .inst_rs1_en   (inst_rs1_en),
        .inst_rs2      (inst_rs2),
        .inst_rs2_en   (inst_rs2_en),
        .inst_rd       (inst_rd),
        .inst_rd_en    (inst_rd_en),
        .inst_unit     (inst_unit),
        .unit_ok       (unit_ok),
        .ops           (u_ops.sel_side),
        .inst_rdy      (inst_rdy),
        .issue_en      (issue_en),
        .issue_rs1_val (issue_rs1_val),
        .issue_rs2_val (issue_rs2_val),
        .issue_rd      (issue_rd),
        .issue_unit    (issue_unit)
    );

endmodule

// ==== hdl/operand_if.sv ====
`include "issue_consts.svh"

interface operand_if
    import issue_pkg::*;
();

    // source ids per slot, from the selector
    preg_id_t                rs1_id   [`ISSUE_WIDTH-1:0];
    preg_id_t                rs2_id   [`ISSUE_WIDTH-1:0];

    // operand data and scoreboard state, from the file
    word_t                   rs1_val  [`ISSUE_WIDTH-1:0];
    word_t                   rs2_val  [`ISSUE_WIDTH-1:0];
    logic [`ISSUE_WIDTH-1:0] rs1_rdy;
    logic [`ISSUE_WIDTH-1:0] rs2_rdy;

    // destinations that go busy after issue
    logic [`ISSUE_WIDTH-1:0] issue_en;
    preg_id_t                rd_id    [`ISSUE_WIDTH-1:0];
    logic [`ISSUE_WIDTH-1:0] rd_en;

    modport reg_side (
        input  rs1_id, rs2_id, issue_en, rd_id, rd_en,
        output rs1_val, rs2_val, rs1_rdy, rs2_rdy
    );

    modport sel_side (
        output rs1_id, rs2_id, issue_en, rd_id, rd_en,
        input  rs1_val, rs2_val, rs1_rdy, rs2_rdy
    );

endinterface

// ==== hdl/phy_reg_file.sv ====
`include "issue_consts.svh"

module phy_reg_file
    import issue_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,

    // writeback from the execution units
    input  logic [`WB_PORTS-1:0] wb_en,
    input  preg_id_t             wb_id   [`WB_PORTS-1:0],
    input  word_t                wb_data [`WB_PORTS-1:0],

    // slot read ports and issue updates
    operand_if.reg_side          ops
);

    // register contents
    word_t                    reg_data [`PHY_REG_NUM-1:0];

    // scoreboard, 1 = value present
    logic [`PHY_REG_NUM-1:0]  reg_rdy;
    logic [`PHY_REG_NUM-1:0]  rdy_nxt;

    // ####################
    // scoreboard update
    // ####################

    always_comb begin
        rdy_nxt = reg_rdy;
        // writeback sets ready
        for (int w = 0; w < `WB_PORTS; w++) begin
            if (wb_en[w]) begin
                rdy_nxt[wb_id[w]] = 1'b1;
            end
        end
        // issued destinations go busy, applied last so issue wins
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            if (ops.issue_en[s] && ops.rd_en[s]) begin
                rdy_nxt[ops.rd_id[s]] = 1'b0;
            end
        end
    end

    // everything ready out of reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            reg_rdy <= '1;
        end else begin
            reg_rdy <= rdy_nxt;
        end
    end

    // ####################
    // data write
    // ####################

    // all registers read zero after reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < `PHY_REG_NUM; r++) begin
                reg_data[r] <= '0;
            end
        end else begin
            for (int w = 0; w < `WB_PORTS; w++) begin
                if (wb_en[w]) begin
                    reg_data[wb_id[w]] <= wb_data[w];
                end
            end
        end
    end

    // ####################
    // read ports
    // ####################

    // no bypass, a read in the writeback cycle sees old data
    for (genvar s = 0; s < `ISSUE_WIDTH; s++) begin : g_rd
        assign ops.rs1_val[s] = reg_data[ops.rs1_id[s]];
        assign ops.rs2_val[s] = reg_data[ops.rs2_id[s]];
        assign ops.rs1_rdy[s] = reg_rdy[ops.rs1_id[s]];
        assign ops.rs2_rdy[s] = reg_rdy[ops.rs2_id[s]];
    end

    // a writeback only completes a register made busy by an earlier issue
    for (genvar w = 0; w < `WB_PORTS; w++) begin : g_wb_chk
        a_wb_to_busy : assert property (
            @(posedge clk) disable iff (!rst_n)
            wb_en[w] |-> !reg_rdy[wb_id[w]]
        ) else $error("writeback port %0d hits ready register %0d", w, wb_id[w]);
    end

endmodule

// ==== hdl/unit_hazard_check.sv ====
`include "issue_consts.svh"

module unit_hazard_check
    import issue_pkg::*;
(
    input  eu_e                       inst_unit   [`ISSUE_WIDTH-1:0],
    input  logic [`LSU_DEPTH_WIDTH:0] inst_lsu_id [`ISSUE_WIDTH-1:0],
    input  logic                      mext_rdy,
    input  logic                      float_rdy,
    input  logic [`LSU_DEPTH_WIDTH:0] lsu_rd_ptr,
    output logic [`ISSUE_WIDTH-1:0]   unit_ok
);

    // unit group per slot, bit 1 mext, bit 0 float or csr
    logic [1:0]              grp      [`ISSUE_WIDTH-1:0];
    // groups claimed by any earlier slot
    logic [1:0]              grp_prev [`ISSUE_WIDTH-1:0];
    logic [`ISSUE_WIDTH-1:0] is_csr;
    logic [`ISSUE_WIDTH-1:0] csr_prev;

    logic [`ISSUE_WIDTH-1:0] grp_ok;
    logic [`ISSUE_WIDTH-1:0] csr_ok;
    logic [`ISSUE_WIDTH-1:0] rdy_ok;
    logic [`ISSUE_WIDTH-1:0] lsu_ok;

    // pointer split into wrap bit and low index
    logic                        ptr_wrap;
    logic [`LSU_DEPTH_WIDTH-1:0] ptr_idx;

    assign ptr_wrap = lsu_rd_ptr[`LSU_DEPTH_WIDTH];
    assign ptr_idx  = lsu_rd_ptr[`LSU_DEPTH_WIDTH-1:0];

    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_slot
        // encode unit group
        assign grp[i]    = {inst_unit[i] == eu_mext,
                            inst_unit[i] == eu_float || inst_unit[i] == eu_csr};
        assign is_csr[i] = inst_unit[i] == eu_csr;

        // ####################
        // window ordering
        // ####################

        // earlier slots counted whether valid or not
        if (i == 0) begin : g_first
            assign grp_prev[i] = 2'b00;
            assign csr_prev[i] = 1'b0;
            assign csr_ok[i]   = 1'b1;
        end else begin : g_rest
            assign grp_prev[i] = grp_prev[i-1] | grp[i-1];
            assign csr_prev[i] = csr_prev[i-1] | is_csr[i-1];
            // csr only from slot 0, and nothing issues behind one
            assign csr_ok[i]   = !is_csr[i] && !csr_prev[i];

            a_csr_slot0 : assert final (!(unit_ok[i] && is_csr[i]))
                else $error("csr accepted in slot %0d", i);
        end

        // one mext and one float/csr per window
        assign grp_ok[i] = ~|(grp[i] & grp_prev[i]);

        // unit ready inputs
        assign rdy_ok[i] = (!grp[i][1] || mext_rdy) && (!grp[i][0] || float_rdy);

        // ####################
        // lsu order
        // ####################

        // id must not be behind the read pointer
        assign lsu_ok[i] = inst_unit[i] != eu_lsu ||
            (inst_lsu_id[i][`LSU_DEPTH_WIDTH] == ptr_wrap &&
             inst_lsu_id[i][`LSU_DEPTH_WIDTH-1:0] >= ptr_idx) ||
            (inst_lsu_id[i][`LSU_DEPTH_WIDTH] != ptr_wrap &&
             inst_lsu_id[i][`LSU_DEPTH_WIDTH-1:0] < ptr_idx);
    end

    assign unit_ok = grp_ok & csr_ok & rdy_ok & lsu_ok;

endmodule

// ==== include/issue_consts.svh ====
`ifndef ISSUE_CONSTS_SVH
`define ISSUE_CONSTS_SVH

// slots in one renamed window
`define ISSUE_WIDTH 4

// physical register file geometry
`define PHY_REG_NUM 64
`define PHY_REG_ID_WIDTH 6

// integer data word
`define REG_WIDTH 32

// writeback ports from the execution units
`define WB_PORTS 2

// lsu buffer index, the id and pointer carry one extra wrap bit
`define LSU_DEPTH_WIDTH 3

`endif

// ==== list.f ====
+incdir+include
hdl/issue_pkg.sv
hdl/operand_if.sv
hdl/phy_reg_file.sv
hdl/unit_hazard_check.sv
hdl/issue_select.sv
hdl/issue_top.sv
tests/tb_clk_gen.sv
tests/tb_issue.sv

// ==== tests/tb_clk_gen.sv ====
module tb_clk_gen #(
    parameter int PERIOD_NS    = 20,
    parameter int RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset low from time zero, released on a falling edge
    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
    end

endmodule

// ==== tests/tb_issue.sv ====
`include "issue_consts.svh"

module tb_issue
    import issue_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    typedef logic [`LSU_DEPTH_WIDTH:0] lsu_id_t;

    localparam int RESET_CYCLES    = 16;
    localparam int DIRECTED_CYCLES = 48;
    localparam int RANDOM_CYCLES   = 400;
    // whole run in ns plus some slack
    localparam int TIMEOUT_NS = (RESET_CYCLES + DIRECTED_CYCLES + RANDOM_CYCLES) * 20 + 2000;

    logic                    clk;
    logic                    rst_n;
    logic [`ISSUE_WIDTH-1:0] inst_vld;
    logic [`ISSUE_WIDTH-1:0] inst_rs1_en;
    logic [`ISSUE_WIDTH-1:0] inst_rs2_en;
    logic [`ISSUE_WIDTH-1:0] inst_rd_en;
    preg_id_t                inst_rs1      [`ISSUE_WIDTH-1:0];
    preg_id_t                inst_rs2      [`ISSUE_WIDTH-1:0];
    preg_id_t                inst_rd       [`ISSUE_WIDTH-1:0];
    eu_e                     inst_unit     [`ISSUE_WIDTH-1:0];
    lsu_id_t                 inst_lsu_id   [`ISSUE_WIDTH-1:0];
    logic                    mext_rdy;
    logic                    float_rdy;
    lsu_id_t                 lsu_rd_ptr;
    logic [`WB_PORTS-1:0]    wb_en;
    preg_id_t                wb_id         [`WB_PORTS-1:0];
    word_t                   wb_data       [`WB_PORTS-1:0];
    logic [`ISSUE_WIDTH-1:0] inst_rdy;
    logic [`ISSUE_WIDTH-1:0] issue_en;
    word_t                   issue_rs1_val [`ISSUE_WIDTH-1:0];
    word_t                   issue_rs2_val [`ISSUE_WIDTH-1:0];
    preg_id_t                issue_rd      [`ISSUE_WIDTH-1:0];
    eu_e                     issue_unit    [`ISSUE_WIDTH-1:0];

    // reference model state and its predictions
    word_t                   mdl_data    [`PHY_REG_NUM-1:0];
    logic [`PHY_REG_NUM-1:0] mdl_rdy;
    logic [`ISSUE_WIDTH-1:0] exp_issue;
    word_t                   exp_rs1_val [`ISSUE_WIDTH-1:0];
    word_t                   exp_rs2_val [`ISSUE_WIDTH-1:0];
    int                      issue_errs;
    int                      value_errs;

    tb_clk_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clk (.clk(clk), .rst_n(rst_n));

    issue_top u_dut (.*);

    // ####################
    // reference model
    // ####################

    // window rules walked slot by slot in program order
    always_comb begin
        logic                        mext_seen;
        logic                        fc_seen;
        logic                        csr_seen;
        logic                        ok;
        logic [`LSU_DEPTH_WIDTH-1:0] lo;
        mext_seen = 1'b0;
        fc_seen   = 1'b0;
        csr_seen  = 1'b0;
        for (int i = 0; i < `ISSUE_WIDTH; i++) begin
            ok = inst_vld[i] && !csr_seen;
            lo = inst_lsu_id[i][`LSU_DEPTH_WIDTH-1:0];
            case (inst_unit[i])
                eu_mext:  ok &= !mext_seen && mext_rdy;
                eu_float: ok &= !fc_seen && float_rdy;
                eu_csr:   ok &= !fc_seen && float_rdy && i == 0;
                eu_lsu: begin
                    // same wrap bit wants lo at or past the pointer and otherwise below it
                    if (inst_lsu_id[i][`LSU_DEPTH_WIDTH] == lsu_rd_ptr[`LSU_DEPTH_WIDTH])
                        ok &= lo >= lsu_rd_ptr[`LSU_DEPTH_WIDTH-1:0];
                    else
                        ok &= lo < lsu_rd_ptr[`LSU_DEPTH_WIDTH-1:0];
                end
                default: ;
            endcase
            if (inst_rs1_en[i])
                ok &= mdl_rdy[inst_rs1[i]];
            if (inst_rs2_en[i])
                ok &= mdl_rdy[inst_rs2[i]];
            // producer earlier in the window
            for (int j = 0; j < i; j++) begin
                if (inst_rd_en[j] && inst_rs1_en[i] && inst_rd[j] == inst_rs1[i])
                    ok = 1'b0;
                if (inst_rd_en[j] && inst_rs2_en[i] && inst_rd[j] == inst_rs2[i])
                    ok = 1'b0;
            end
            exp_issue[i]   = ok;
            exp_rs1_val[i] = mdl_data[inst_rs1[i]];
            exp_rs2_val[i] = mdl_data[inst_rs2[i]];
            mext_seen |= inst_unit[i] == eu_mext;
            fc_seen   |= inst_unit[i] == eu_float || inst_unit[i] == eu_csr;
            csr_seen  |= inst_unit[i] == eu_csr;
        end
    end

    // writeback sets ready and issue clears it afterwards so issue wins
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mdl_rdy <= '1;
            for (int r = 0; r < `PHY_REG_NUM; r++) begin
                mdl_data[r] <= '0;
            end
        end else begin
            for (int w = 0; w < `WB_PORTS; w++) begin
                if (wb_en[w]) begin
                    mdl_rdy[wb_id[w]]  <= 1'b1;
                    mdl_data[wb_id[w]] <= wb_data[w];
                end
            end
            for (int s = 0; s < `ISSUE_WIDTH; s++) begin
                if (exp_issue[s] && inst_rd_en[s]) begin
                    mdl_rdy[inst_rd[s]] <= 1'b0;
                end
            end
        end
    end

    // ####################
    // checks
    // ####################

    task automatic log_issue_error(input string what, input logic [`ISSUE_WIDTH-1:0] got,
                                   input logic [`ISSUE_WIDTH-1:0] exp);
        issue_errs++;
        $display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
    endtask

    task automatic log_value_error(input string what, input word_t got, input word_t exp);
        value_errs++;
        $display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
    endtask

    a_issue : assert property (@(posedge clk) disable iff (!rst_n) issue_en == exp_issue)
        else log_issue_error("issue_en", $sampled(issue_en), $sampled(exp_issue));

    a_rdy : assert property (@(posedge clk) disable iff (!rst_n) inst_rdy == issue_en)
        else log_issue_error("inst_rdy", $sampled(inst_rdy), $sampled(issue_en));

    // read ports checked every cycle so the writeback cycle shows old data
    for (genvar i = 0; i < `ISSUE_WIDTH; i++) begin : g_chk
        a_rs1 : assert property (@(posedge clk) disable iff (!rst_n)
            issue_rs1_val[i] == exp_rs1_val[i])
            else log_value_error($sformatf("slot %0d rs1 value", i),
                                 $sampled(issue_rs1_val[i]), $sampled(exp_rs1_val[i]));
        a_rs2 : assert property (@(posedge clk) disable iff (!rst_n)
            issue_rs2_val[i] == exp_rs2_val[i])
            else log_value_error($sformatf("slot %0d rs2 value", i),
                                 $sampled(issue_rs2_val[i]), $sampled(exp_rs2_val[i]));
        a_rd : assert property (@(posedge clk) disable iff (!rst_n)
            issue_en[i] |-> issue_rd[i] == inst_rd[i])
            else log_value_error($sformatf("slot %0d rd", i),
                                 word_t'($sampled(issue_rd[i])), word_t'($sampled(inst_rd[i])));
        a_unit : assert property (@(posedge clk) disable iff (!rst_n)
            issue_en[i] |-> issue_unit[i] == inst_unit[i])
            else log_value_error($sformatf("slot %0d unit", i),
                                 word_t'($sampled(issue_unit[i])),
                                 word_t'($sampled(inst_unit[i])));
    end

    // ####################
    // stimulus
    // ####################

    task automatic clear_window();
        inst_vld    = '0;
        inst_rs1_en = '0;
        inst_rs2_en = '0;
        inst_rd_en  = '0;
        wb_en       = '0;
        mext_rdy    = 1'b1;
        float_rdy   = 1'b1;
        lsu_rd_ptr  = '0;
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            inst_rs1[s]    = '0;
            inst_rs2[s]    = '0;
            inst_rd[s]     = '0;
            inst_unit[s]   = eu_alu;
            inst_lsu_id[s] = '0;
        end
        for (int w = 0; w < `WB_PORTS; w++) begin
            wb_id[w]   = '0;
            wb_data[w] = '0;
        end
    endtask

    task automatic next_window();
        @(negedge clk);
        clear_window();
    endtask

    // a negative register id leaves that field unused
    task automatic put_slot(input int s, input eu_e unit, input int rs1, input int rs2,
                            input int rd);
        inst_vld[s]    = 1'b1;
        inst_unit[s]   = unit;
        inst_rs1_en[s] = rs1 >= 0;
        inst_rs2_en[s] = rs2 >= 0;
        inst_rd_en[s]  = rd >= 0;
        inst_rs1[s]    = preg_id_t'(rs1);
        inst_rs2[s]    = preg_id_t'(rs2);
        inst_rd[s]     = preg_id_t'(rd);
    endtask

    task automatic put_wb(input int w, input int id, input word_t data);
        wb_en[w]   = 1'b1;
        wb_id[w]   = preg_id_t'(id);
        wb_data[w] = data;
    endtask

    // busy register searched from a random start or -1 when none is busy
    function automatic int pick_busy(input int skip);
        int start;
        int r;
        start = $urandom_range(0, `PHY_REG_NUM - 1);
        for (int k = 0; k < `PHY_REG_NUM; k++) begin
            r = (start + k) % `PHY_REG_NUM;
            if (!mdl_rdy[r] && r != skip)
                return r;
        end
        return -1;
    endfunction

    task automatic random_window();
        int id;
        next_window();
        mext_rdy   = $urandom_range(0, 3) != 0;
        float_rdy  = $urandom_range(0, 3) != 0;
        lsu_rd_ptr = lsu_id_t'($urandom_range(0, 15));
        for (int s = 0; s < `ISSUE_WIDTH; s++) begin
            inst_vld[s]    = $urandom_range(0, 3) != 0;
            inst_unit[s]   = eu_e'($urandom_range(0, 4));
            inst_rs1_en[s] = $urandom_range(0, 1) == 1;
            inst_rs2_en[s] = $urandom_range(0, 1) == 1;
            inst_rd_en[s]  = $urandom_range(0, 1) == 1;
            inst_rs1[s]    = preg_id_t'($urandom_range(0, `PHY_REG_NUM - 1));
            inst_rs2[s]    = preg_id_t'($urandom_range(0, `PHY_REG_NUM - 1));
            inst_rd[s]     = preg_id_t'($urandom_range(0, `PHY_REG_NUM - 1));
            inst_lsu_id[s] = lsu_id_t'($urandom_range(0, 15));
        end
        // writebacks only complete busy registers and never share one between ports
        for (int w = 0; w < `WB_PORTS; w++) begin
            id = pick_busy(wb_en[0] ? int'(wb_id[0]) : -1);
            if (id >= 0 && $urandom_range(0, 1) == 1)
                put_wb(w, id, $urandom);
        end
    endtask

    initial begin
        issue_errs = 0;
        value_errs = 0;
        void'($urandom(32'h4b8a_5e9c));
        clear_window();
        @(posedge rst_n);
        // idle windows and then every register read as zero and ready
        repeat (2) next_window();
        for (int c = 0; c < `PHY_REG_NUM / `ISSUE_WIDTH; c++) begin
            next_window();
            for (int s = 0; s < `ISSUE_WIDTH; s++)
                put_slot(s, eu_alu, c * 4 + s, `PHY_REG_NUM - 1 - (c * 4 + s), -1);
        end
        // busy rd and then issue plus writeback on one edge keep it busy
        next_window();
        put_slot(0, eu_alu, -1, -1, 10);
        next_window();
        put_wb(0, 10, 32'hcafe_0010);
        put_slot(0, eu_alu, -1, -1, 10);
        put_slot(1, eu_alu, 10, -1, -1);
        next_window();
        put_slot(0, eu_alu, 10, -1, -1);
        next_window();
        put_wb(1, 10, 32'h5eed_0a0a);
        next_window();
        put_slot(0, eu_alu, 10, 10, -1);
        // unit group hazards
        next_window();
        put_slot(0, eu_mext, 1, 2, -1);
        put_slot(1, eu_mext, 3, -1, -1);
        put_slot(2, eu_float, -1, -1, -1);
        put_slot(3, eu_csr, -1, -1, -1);
        // unit ready inputs low
        next_window();
        mext_rdy  = 1'b0;
        float_rdy = 1'b0;
        put_slot(0, eu_mext, -1, -1, -1);
        put_slot(1, eu_float, -1, -1, -1);
        put_slot(2, eu_alu, -1, -1, -1);
        // csr in slot 0 blocks the rest
        next_window();
        put_slot(0, eu_csr, -1, -1, -1);
        put_slot(1, eu_alu, -1, -1, -1);
        put_slot(2, eu_lsu, -1, -1, -1);
        next_window();
        put_slot(2, eu_csr, -1, -1, -1);
        // lsu order around the wrap bit
        next_window();
        lsu_rd_ptr = 4'b0100;
        for (int s = 0; s < `ISSUE_WIDTH; s++)
            put_slot(s, eu_lsu, -1, -1, -1);
        inst_lsu_id[0] = 4'b0101;
        inst_lsu_id[1] = 4'b0011;
        inst_lsu_id[2] = 4'b1010;
        inst_lsu_id[3] = 4'b1110;
        // raw inside the window
        next_window();
        put_slot(0, eu_alu, -1, -1, 20);
        put_slot(1, eu_alu, 20, -1, -1);
        put_slot(2, eu_alu, -1, 20, -1);
        put_slot(3, eu_alu, 21, -1, -1);
        repeat (RANDOM_CYCLES) random_window();
        repeat (2) next_window();
        $display("issue errors %0d, value errors %0d", issue_errs, value_errs);
        if (issue_errs + value_errs == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired before the tests finished");
        $display("Checks failed");
        $finish;
    end

endmodule
